//--- all.f
verilog/icache_pkg.sv
verilog/icache_lookup.sv
verilog/refill_bridge.sv
verilog/axi_rd_master.sv
verilog/icache_top.sv
dv/axi_rd_slave.sv
dv/tb_icache.sv

//--- Makefile
# Verilator flow for the fetch cache testbench
# Any variable below can be overridden, e.g. make sim LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_TEXT ?= SIMULATION PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only if the log holds the pass line
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_icache.sv
// Cache testbench; 16 sets so conflicts are frequent, memory data is address xor a fixed mask
`timescale 1ns/100ps

module tb_icache;

  localparam int unsigned NUM_SETS   = 16;
  localparam int unsigned LINE_BYTES = 16;
  localparam int unsigned TIMEOUT    = 500;
  localparam logic [31:0] MEM_MASK   = 32'h5A5A0000;
  localparam logic [31:0] SEED       = 32'h0629c38c;

  logic                   clk;
  logic                   rst;
  logic                   flush;
  logic                   fetch_valid;
  icache_pkg::fetch_req_t fetch_req;
  logic                   arready;
  logic                   rvalid;
  icache_pkg::axi_r_t     r;
  logic                   fetch_ready;
  logic                   fetch_rsp_valid;
  icache_pkg::fetch_rsp_t fetch_rsp;
  logic                   miss;
  logic                   arvalid;
  icache_pkg::axi_ar_t    ar;
  logic                   rready;

  // Reference model holds one tag per set
  bit          model_valid [NUM_SETS];
  logic [31:0] model_tag   [NUM_SETS];

  int unsigned errors;
  int unsigned fetches;
  int unsigned misses_total;
  logic [31:0] resident[$];

  icache_top #(
    .NUM_SETS (NUM_SETS),
    .RD_TX_ID (4'h5)
  ) dut (
    .clk_i             (clk),
    .rst_i             (rst),
    .flush_i           (flush),
    .fetch_valid_i     (fetch_valid),
    .fetch_req_i       (fetch_req),
    .arready_i         (arready),
    .rvalid_i          (rvalid),
    .r_i               (r),
    .fetch_ready_o     (fetch_ready),
    .fetch_rsp_valid_o (fetch_rsp_valid),
    .fetch_rsp_o       (fetch_rsp),
    .miss_o            (miss),
    .arvalid_o         (arvalid),
    .ar_o              (ar),
    .rready_o          (rready)
  );

  axi_rd_slave #(
    .DATA_MASK (MEM_MASK)
  ) u_mem (
    .clk_i     (clk),
    .rst_i     (rst),
    .arvalid_i (arvalid),
    .ar_i      (ar),
    .rready_i  (rready),
    .arready_o (arready),
    .rvalid_o  (rvalid),
    .r_o       (r)
  );

  always #2 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  // Cached address from 4 tags over all sets
  function automatic logic [31:0] random_cached_addr();
    logic [31:0] a;
    a = 32'h0000_4000;
    a = a + LINE_BYTES * ($urandom_range(0, 3) * NUM_SETS + $urandom_range(0, NUM_SETS - 1));
    a = a + 4 * $urandom_range(0, 3);
    return a;
  endfunction

  task automatic fetch_and_check(input logic [31:0] addr, input string name);
    int unsigned idx;
    logic [31:0] tag;
    bit          nc;
    bit          exp_miss;
    bit          accepted;
    bit          got;
    int unsigned cycles;
    int unsigned miss_seen;
    int unsigned ar_seen;
    logic [31:0] ar_addr;
    logic [31:0] ar_len;
    logic [31:0] rsp_data;
    logic [31:0] rsp_addr;
    nc       = addr[31];
    idx      = (addr / LINE_BYTES) % NUM_SETS;
    tag      = addr / (LINE_BYTES * NUM_SETS);
    exp_miss = !nc && !(model_valid[idx] && model_tag[idx] == tag);
    fetch_valid    <= 1'b1;
    fetch_req.addr <= addr;
    accepted = 1'b0;
    cycles   = 0;
    while (!accepted && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      accepted = fetch_ready;
    end
    fetch_valid <= 1'b0;
    if (!accepted) begin
      errors++;
      $display("Fetch of 0x%08h in %s was never accepted", addr, name);
      return;
    end
    // Watch miss_o and AR until the response pulse
    got       = 1'b0;
    cycles    = 0;
    miss_seen = 0;
    ar_seen   = 0;
    ar_addr   = '0;
    ar_len    = '0;
    rsp_data  = '0;
    rsp_addr  = '0;
    while (!got && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (miss) begin
        miss_seen++;
      end
      if (arvalid && arready) begin
        ar_seen++;
        ar_addr = ar.addr;
        ar_len  = {24'd0, ar.len};
      end
      if (fetch_rsp_valid) begin
        got      = 1'b1;
        rsp_data = fetch_rsp.data;
        rsp_addr = fetch_rsp.addr;
      end
    end
    if (!got) begin
      errors++;
      $display("No response to fetch of 0x%08h in %s", addr, name);
      return;
    end
    check_value({name, " data"}, addr ^ MEM_MASK, rsp_data);
    check_value({name, " rsp addr"}, addr, rsp_addr);
    check_value({name, " miss pulses"}, {31'd0, exp_miss}, miss_seen);
    check_value({name, " AR count"}, {31'd0, nc | exp_miss}, ar_seen);
    if (nc) begin
      check_value({name, " AR addr"}, addr, ar_addr);
      check_value({name, " AR len"}, 32'd0, ar_len);
    end else if (exp_miss) begin
      check_value({name, " AR addr"}, addr & ~32'(LINE_BYTES - 1), ar_addr);
      check_value({name, " AR len"}, 32'd3, ar_len);
    end else begin
      check_value({name, " hit latency"}, 32'd2, cycles);
    end
    if (exp_miss) begin
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tag;
      misses_total++;
    end
    fetches++;
  endtask

  // Flush lands on an edge where the FSM is idle
  task automatic flush_cache();
    int unsigned cycles;
    bit          seen;
    flush  <= 1'b1;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      seen = fetch_ready;
    end
    flush <= 1'b0;
    if (!seen) begin
      errors++;
      $display("Flush was never taken, cache stayed busy");
    end
    for (int s = 0; s < NUM_SETS; s++) begin
      model_valid[s] = 1'b0;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    clk            = 1'b0;
    rst            <= 1'b1;
    flush          <= 1'b0;
    fetch_valid    <= 1'b0;
    fetch_req      <= '0;
    errors         = 0;
    fetches        = 0;
    misses_total   = 0;
    for (int s = 0; s < NUM_SETS; s++) begin
      model_valid[s] = 1'b0;
      model_tag[s]   = '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // Ready stays low for one cycle after reset and the bus is quiet
    check_value("reset fetch_ready", 32'd0, {31'd0, fetch_ready});
    check_value("reset fetch_rsp_valid", 32'd0, {31'd0, fetch_rsp_valid});
    check_value("reset miss", 32'd0, {31'd0, miss});
    check_value("reset arvalid", 32'd0, {31'd0, arvalid});
    check_value("rready", 32'd1, {31'd0, rready});
    // One line fill, then all four words hit
    fetch_and_check(32'h0000_1008, "line fill");
    for (int w = 0; w < 4; w++) begin
      fetch_and_check(32'h0000_1000 + 32'(4 * w), "line words");
    end
    // Bypassed word goes to the bus every time
    fetch_and_check(32'h8000_0124, "uncached");
    fetch_and_check(32'h8000_0124, "uncached repeat");
    // Two tags in one set miss on every fetch
    for (int k = 0; k < 6; k++) begin
      fetch_and_check(32'h0000_2034 + 32'((k % 2) * LINE_BYTES * NUM_SETS), "conflict");
    end
    // Random mix with about one in five bypassed
    for (int i = 0; i < 200; i++) begin
      if ($urandom_range(0, 4) == 0) begin
        fetch_and_check(32'h8000_0000 | 32'(4 * $urandom_range(0, 255)), "random uncached");
      end else begin
        fetch_and_check(random_cached_addr(), "random cached");
      end
    end
    // Remember what is resident, then flush and refetch it
    for (int s = 0; s < NUM_SETS; s++) begin
      if (model_valid[s]) begin
        resident.push_back(model_tag[s] * (LINE_BYTES * NUM_SETS) + 32'(s * LINE_BYTES));
      end
    end
    if (resident.size() == 0) begin
      errors++;
      $display("No line was resident before the flush");
    end
    flush_cache();
    foreach (resident[i]) begin
      fetch_and_check(resident[i], "after flush");
    end
    $display("Fetches %0d, misses %0d, errors %0d", fetches, misses_total, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- dv/axi_rd_slave.sv
// AXI read memory for simulation; INCR bursts only, one burst at a time, data = address xor mask
`timescale 1ns/100ps

module axi_rd_slave #(
  parameter logic [31:0] DATA_MASK = 32'h5A5A0000
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                arvalid_i,
  input  icache_pkg::axi_ar_t ar_i,
  input  logic                rready_i,
  output logic                arready_o,
  output logic                rvalid_o,
  output icache_pkg::axi_r_t  r_o
);

  logic                        busy_q;
  logic [31:0]                 addr_q;
  logic [7:0]                  len_q;
  logic [7:0]                  beat_q;
  logic [icache_pkg::ID_W-1:0] id_q;

  // Outputs known from time 0
  initial begin
    arready_o <= 1'b0;
    rvalid_o  <= 1'b0;
    r_o       <= '0;
    busy_q    <= 1'b0;
    beat_q    <= 8'd0;
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      r_o       <= '0;
      busy_q    <= 1'b0;
      beat_q    <= 8'd0;
    end else if (!busy_q) begin
      if (arvalid_i && arready_o) begin
        // Take the burst, close AR until it is done
        arready_o <= 1'b0;
        busy_q    <= 1'b1;
        addr_q    <= ar_i.addr;
        len_q     <= ar_i.len;
        id_q      <= ar_i.id;
        beat_q    <= 8'd0;
      end else begin
        // Random AR stall
        arready_o <= ($urandom_range(0, 2) == 0);
      end
    end else if (!rvalid_o || rready_i) begin
      if (rvalid_o && r_o.last) begin
        rvalid_o <= 1'b0;
        busy_q   <= 1'b0;
      end else if ($urandom_range(0, 3) == 0) begin
        // Random gap between beats
        rvalid_o <= 1'b0;
      end else begin
        rvalid_o   <= 1'b1;
        r_o.data   <= (addr_q + {22'd0, beat_q, 2'b00}) ^ DATA_MASK;
        r_o.last   <= (beat_q == len_q);
        r_o.id     <= id_q;
        r_o.resp   <= 2'b00;
        beat_q     <= beat_q + 8'd1;
      end
    end
  end

endmodule

//--- verilog/icache_top.sv
// Fetch cache top; only the AXI read channels are present and one refill is in flight at a time
`timescale 1ns/100ps

module icache_top #(
  parameter int unsigned                 NUM_SETS = 64,
  parameter logic [icache_pkg::ID_W-1:0] RD_TX_ID = '0
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   flush_i,
  input  logic                   fetch_valid_i,
  input  icache_pkg::fetch_req_t fetch_req_i,
  input  logic                   arready_i,
  input  logic                   rvalid_i,
  input  icache_pkg::axi_r_t     r_i,
  output logic                   fetch_ready_o,
  output logic                   fetch_rsp_valid_o,
  output icache_pkg::fetch_rsp_t fetch_rsp_o,
  output logic                   miss_o,
  output logic                   arvalid_o,
  output icache_pkg::axi_ar_t    ar_o,
  output logic                   rready_o
);

  // Lookup to bridge
  logic                     refill_req_valid;
  icache_pkg::refill_req_t  refill_req;
  logic                     refill_rtrn_valid;
  icache_pkg::refill_rtrn_t refill_rtrn;

  // Bridge to master
  logic                rd_req;
  logic                rd_gnt;
  icache_pkg::axi_ar_t rd_ar;
  logic                rd_beat_valid;
  icache_pkg::axi_r_t  rd_beat;

  icache_lookup #(
    .NUM_SETS (NUM_SETS)
  ) u_lookup (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .flush_i             (flush_i),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_req_i         (fetch_req_i),
    .refill_rtrn_valid_i (refill_rtrn_valid),
    .refill_rtrn_i       (refill_rtrn),
    .fetch_ready_o       (fetch_ready_o),
    .fetch_rsp_valid_o   (fetch_rsp_valid_o),
    .fetch_rsp_o         (fetch_rsp_o),
    .miss_o              (miss_o),
    .refill_req_valid_o  (refill_req_valid),
    .refill_req_o        (refill_req)
  );

  refill_bridge #(
    .RD_TX_ID (RD_TX_ID)
  ) u_bridge (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .refill_req_valid_i  (refill_req_valid),
    .refill_req_i        (refill_req),
    .rd_gnt_i            (rd_gnt),
    .rd_beat_valid_i     (rd_beat_valid),
    .rd_beat_i           (rd_beat),
    .refill_rtrn_valid_o (refill_rtrn_valid),
    .refill_rtrn_o       (refill_rtrn),
    .rd_req_o            (rd_req),
    .rd_ar_o             (rd_ar)
  );

  axi_rd_master u_master (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .rd_req_i        (rd_req),
    .rd_ar_i         (rd_ar),
    .arready_i       (arready_i),
    .rvalid_i        (rvalid_i),
    .r_i             (r_i),
    .rd_gnt_o        (rd_gnt),
    .arvalid_o       (arvalid_o),
    .ar_o            (ar_o),
    .rready_o        (rready_o),
    .rd_beat_valid_o (rd_beat_valid),
    .rd_beat_o       (rd_beat)
  );

endmodule

//--- verilog/axi_rd_master.sv
// AXI read master; single outstanding AR, R channel always ready, no write channels
`timescale 1ns/100ps

module axi_rd_master (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                rd_req_i,
  input  icache_pkg::axi_ar_t rd_ar_i,
  input  logic                arready_i,
  input  logic                rvalid_i,
  input  icache_pkg::axi_r_t  r_i,
  output logic                rd_gnt_o,
  output logic                arvalid_o,
  output icache_pkg::axi_ar_t ar_o,
  output logic                rready_o,
  output logic                rd_beat_valid_o,
  output icache_pkg::axi_r_t  rd_beat_o
);

  logic                arvalid_q;
  logic                busy_q;
  icache_pkg::axi_ar_t ar_q;
  logic                launch;
  logic                ar_done;

  // A new AR waits for the previous burst to finish
  assign launch  = rd_req_i & ~arvalid_q & ~busy_q;
  assign ar_done = arvalid_q & arready_i;

  // Grant in the handshake cycle
  assign rd_gnt_o  = ar_done;
  assign arvalid_o = arvalid_q;
  assign ar_o      = ar_q;

  assign rready_o = 1'b1;

  // Beats outside a burst are not ours
  assign rd_beat_valid_o = rvalid_i & busy_q;
  assign rd_beat_o       = r_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      arvalid_q <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      if (ar_done) begin
        arvalid_q <= 1'b0;
      end else if (launch) begin
        arvalid_q <= 1'b1;
      end
      if (launch) begin
        busy_q <= 1'b1;
      end else if (rvalid_i && r_i.last) begin
        busy_q <= 1'b0;
      end
    end
  end

  // AR payload stays put while arvalid is high
  always_ff @(posedge clk_i) begin
    if (launch) begin
      ar_q <= rd_ar_i;
    end
  end

endmodule

//--- verilog/refill_bridge.sv
// Refill bridge; one request at a time, beats must carry the request id, bridge is always ready
`timescale 1ns/100ps

module refill_bridge #(
  parameter logic [icache_pkg::ID_W-1:0] RD_TX_ID = '0
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     refill_req_valid_i,
  input  icache_pkg::refill_req_t  refill_req_i,
  input  logic                     rd_gnt_i,
  input  logic                     rd_beat_valid_i,
  input  icache_pkg::axi_r_t       rd_beat_i,
  output logic                     refill_rtrn_valid_o,
  output icache_pkg::refill_rtrn_t refill_rtrn_o,
  output logic                     rd_req_o,
  output icache_pkg::axi_ar_t      rd_ar_o
);

  logic                    pend_q;
  icache_pkg::refill_req_t req_q;
  icache_pkg::refill_req_t req_cur;
  logic                    first_q, first_d;
  icache_pkg::line_t       line_q, line_d;
  logic                    beat_ok;

  // New request wins over the held copy
  assign req_cur = refill_req_valid_i ? refill_req_i : req_q;

  // Pending until the master grants, since the lookup pulses only once
  assign rd_req_o = refill_req_valid_i | pend_q;

  // Whole line for a miss, one word at its own address when bypassed
  assign rd_ar_o.addr  = req_cur.nc ? req_cur.paddr :
                         {req_cur.paddr[icache_pkg::ADDR_W-1:icache_pkg::LINE_OFF_W],
                          {icache_pkg::LINE_OFF_W{1'b0}}};
  assign rd_ar_o.len   = req_cur.nc ? 8'd0 : 8'(icache_pkg::LINE_WORDS - 1);
  assign rd_ar_o.size  = 3'(icache_pkg::BYTE_OFF_W);
  assign rd_ar_o.burst = icache_pkg::INCR;
  assign rd_ar_o.id    = req_cur.tid;

  // Beats of some other transaction are dropped
  assign beat_ok = rd_beat_valid_i & (rd_beat_i.id == req_q.tid);

  // Beat shifter
  always_comb begin
    first_d = first_q;
    line_d  = line_q;
    if (beat_ok) begin
      first_d = rd_beat_i.last;
      // Newest beat enters at the top, older ones move down a word
      line_d  = {rd_beat_i.data, line_q[icache_pkg::LINE_WORDS-1:1]};
      // Single-word case lands at offset 0
      if (first_q) begin
        line_d[0] = rd_beat_i.data;
      end
    end
  end

  // Line returns on the last beat, not a cycle later
  assign refill_rtrn_valid_o = beat_ok & rd_beat_i.last;
  assign refill_rtrn_o.data  = line_d;
  assign refill_rtrn_o.tid   = RD_TX_ID;
  // Error code passed through as is
  assign refill_rtrn_o.resp  = rd_beat_i.resp;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q  <= 1'b0;
      first_q <= 1'b1;
    end else begin
      pend_q  <= ~rd_gnt_i & (refill_req_valid_i | pend_q);
      first_q <= first_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_req_valid_i) begin
      req_q <= refill_req_i;
    end
    line_q <= line_d;
  end

endmodule

//--- verilog/icache_lookup.sv
// Direct-mapped lookup; word-aligned addresses only, bit 31 set means uncached, one miss in flight
`timescale 1ns/100ps

module icache_lookup #(
  parameter int unsigned NUM_SETS = 64
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  input  logic                     fetch_valid_i,
  input  icache_pkg::fetch_req_t   fetch_req_i,
  input  logic                     refill_rtrn_valid_i,
  input  icache_pkg::refill_rtrn_t refill_rtrn_i,
  output logic                     fetch_ready_o,
  output logic                     fetch_rsp_valid_o,
  output icache_pkg::fetch_rsp_t   fetch_rsp_o,
  output logic                     miss_o,
  output logic                     refill_req_valid_o,
  output icache_pkg::refill_req_t  refill_req_o
);

  localparam int unsigned IDX_W = $clog2(NUM_SETS);
  localparam int unsigned TAG_W = icache_pkg::ADDR_W - IDX_W - icache_pkg::LINE_OFF_W;

  icache_pkg::lookup_state_e state_q, state_d;
  logic                      ready_q;

  // Request held from accept until the next accept
  icache_pkg::fetch_req_t req_q;
  logic [icache_pkg::WORD_W-1:0] rsp_data_q;

  // Arrays; only the valid bits are control state
  logic [NUM_SETS-1:0] valid_q;
  logic [TAG_W-1:0]    tag_q  [NUM_SETS];
  icache_pkg::line_t   data_q [NUM_SETS];

  logic [IDX_W-1:0]                  req_idx;
  logic [TAG_W-1:0]                  req_tag;
  logic [icache_pkg::WORD_OFF_W-1:0] req_word;
  logic                              req_nc;
  logic                              accept;
  logic                              hit;
  logic                              rtrn_done;
  logic                              fill_en;

  // Field split of the held address
  assign req_idx  = req_q.addr[icache_pkg::LINE_OFF_W +: IDX_W];
  assign req_tag  = req_q.addr[icache_pkg::ADDR_W-1 -: TAG_W];
  assign req_word = req_q.addr[icache_pkg::BYTE_OFF_W +: icache_pkg::WORD_OFF_W];
  assign req_nc   = req_q.addr[icache_pkg::ADDR_W-1];

  assign fetch_ready_o = ready_q;
  assign accept        = fetch_valid_i & ready_q;

  // Uncached addresses never hit, even if a stale tag matched
  assign hit = valid_q[req_idx] & (tag_q[req_idx] == req_tag) & ~req_nc;

  assign rtrn_done = (state_q == icache_pkg::REFILL) & refill_rtrn_valid_i;
  assign fill_en   = rtrn_done & ~req_nc;

  // Miss counter pulse excludes bypassed fetches
  assign miss_o = (state_q == icache_pkg::COMPARE) & ~hit & ~req_nc;

  // One refill per miss or uncached fetch, a single-cycle pulse
  assign refill_req_valid_o = (state_q == icache_pkg::COMPARE) & ~hit;
  assign refill_req_o.paddr = req_q.addr;
  assign refill_req_o.nc    = req_nc;
  assign refill_req_o.tid   = '0;

  assign fetch_rsp_valid_o = (state_q == icache_pkg::RESPOND);
  assign fetch_rsp_o.data  = rsp_data_q;
  assign fetch_rsp_o.addr  = req_q.addr;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      icache_pkg::IDLE: begin
        if (accept) begin
          state_d = icache_pkg::COMPARE;
        end
      end
      icache_pkg::COMPARE: begin
        state_d = hit ? icache_pkg::RESPOND : icache_pkg::REFILL;
      end
      icache_pkg::REFILL: begin
        if (refill_rtrn_valid_i) begin
          state_d = icache_pkg::RESPOND;
        end
      end
      icache_pkg::RESPOND: begin
        state_d = icache_pkg::IDLE;
      end
      default: begin
        state_d = icache_pkg::IDLE;
      end
    endcase
  end

  // FSM, ready flag and valid bits
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= icache_pkg::IDLE;
      ready_q <= 1'b0;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      // Ready follows the next state, so it stays low in the first cycle after reset
      ready_q <= (state_d == icache_pkg::IDLE);
      // Flush only counts in IDLE and takes this single edge
      if ((state_q == icache_pkg::IDLE) && flush_i) begin
        valid_q <= '0;
      end else if (fill_en) begin
        valid_q[req_idx] <= 1'b1;
      end
    end
  end

  // Request and response words
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= fetch_req_i;
    end
    if ((state_q == icache_pkg::COMPARE) && hit) begin
      rsp_data_q <= data_q[req_idx][req_word];
    end else if (rtrn_done) begin
      // Bypassed word arrives at offset 0 of the returned line
      rsp_data_q <= req_nc ? refill_rtrn_i.data[0] : refill_rtrn_i.data[req_word];
    end
  end

  // Line fill
  always_ff @(posedge clk_i) begin
    if (fill_en) begin
      tag_q[req_idx]  <= req_tag;
      data_q[req_idx] <= refill_rtrn_i.data;
    end
  end

endmodule

//--- verilog/icache_pkg.sv
// Shared widths and types; line geometry and AXI field widths are fixed here for all blocks
package icache_pkg;

  // Bus and fetch widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned WORD_W     = 32;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned ID_W       = 4;

  // Address split below the set index
  localparam int unsigned BYTE_OFF_W = $clog2(WORD_W / 8);
  localparam int unsigned WORD_OFF_W = $clog2(LINE_WORDS);
  localparam int unsigned LINE_OFF_W = BYTE_OFF_W + WORD_OFF_W;

  // One cache line, word 0 at the lowest address
  typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic [ADDR_W-1:0] addr;
  } fetch_rsp_t;

  // Miss or uncached request toward the refill bridge
  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              nc;
    logic [ID_W-1:0]   tid;
  } refill_req_t;

  typedef struct packed {
    line_t           data;
    logic [ID_W-1:0] tid;
    logic [1:0]      resp;
  } refill_rtrn_t;

  // AR burst encodings as on the bus
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    axi_burst_e        burst;
    logic [ID_W-1:0]   id;
  } axi_ar_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              last;
    logic [ID_W-1:0]   id;
    logic [1:0]        resp;
  } axi_r_t;

  typedef enum logic [1:0] {
    IDLE,
    COMPARE,
    REFILL,
    RESPOND
  } lookup_state_e;

endpackage
